// ==== Makefile ====
SIM       := verilator
SIM_FLAGS := --binary --timing --assert -j 0
TOP       := tb_bpu
FILELIST  := bpu.f
BUILD_DIR := obj_dir
PASS_MSG  := ALL TESTS PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// ==== bpu.f ====
+incdir+include
design/bpu_pkg.sv
design/bpu_ctrl.sv
design/fetch_pc_gen.sv
design/branch_history.sv
design/ubtb.sv
design/pred_pipe.sv
design/bpu_top.sv
sim/tb_bpu.sv

// ==== design/bpu_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module bpu_ctrl (
    input  wire  clk,
    input  wire  rst,
    input  wire  i_squash_vld,
    input  wire  i_ftq_rdy,
    output logic o_advance,
    output logic o_s1_vld,
    output logic o_s2_vld
);

    bpu_pkg::ctrl_state_t state_q;

    // hold off lookups for one cycle after reset, then run
    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= bpu_pkg::ST_IDLE;
        end else begin
            case (state_q)
                bpu_pkg::ST_IDLE: state_q <= bpu_pkg::ST_RUN;
                bpu_pkg::ST_RUN:  state_q <= bpu_pkg::ST_RUN;
                default:          state_q <= bpu_pkg::ST_IDLE;
            endcase
        end
    end

    // all stages move together, s2 frees up when empty or taken by the queue
    assign o_advance = (state_q == bpu_pkg::ST_RUN) && (!o_s2_vld || i_ftq_rdy);

    // valid token through s1 and s2
    always_ff @(posedge clk) begin
        if (rst) begin
            o_s1_vld <= 1'b0;
            o_s2_vld <= 1'b0;
        end else if (i_squash_vld) begin
            o_s1_vld <= 1'b0;
            o_s2_vld <= 1'b0;
        end else if (o_advance) begin
            // s0 always holds a lookup while running
            o_s1_vld <= 1'b1;
            o_s2_vld <= o_s1_vld;
        end
    end

    // s2 only fills from an occupied s1
    a_s2_from_s1: assert property (@(posedge clk) disable iff (rst)
        $rose(o_s2_vld) |-> $past(o_s1_vld && o_advance));

    // squash flushes both stages at the next edge
    a_squash_flush: assert property (@(posedge clk) disable iff (rst)
        i_squash_vld |=> (!o_s1_vld && !o_s2_vld));

endmodule

`default_nettype wire

// ==== design/bpu_pkg.sv ====
`default_nettype none

`include "bpu_defs.svh"

package bpu_pkg;

    // byte address
    typedef logic [`BPU_XLEN-1:0] addr_t;

    // global history, newest outcome in bit 0
    typedef logic [`BPU_HIST_LEN-1:0] ghist_t;

    // ubtb index, taken just above the block offset
    typedef logic [`BPU_UBTB_IDX_W-1:0] ubtb_idx_t;

    // remaining upper address bits
    typedef logic [`BPU_XLEN-`BPU_OFF_W-`BPU_UBTB_IDX_W-1:0] ubtb_tag_t;

    // front end control
    typedef enum logic {
        ST_IDLE = 1'b0,
        ST_RUN  = 1'b1
    } ctrl_state_t;

endpackage

`default_nettype wire

// ==== design/bpu_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module bpu_top (
    input  wire                 clk,
    input  wire                 rst,
    input  wire                 i_squash_vld,
    input  wire bpu_pkg::addr_t i_squash_pc,
    input  wire                 i_commit_vld,
    input  wire                 i_commit_is_cond,
    input  wire bpu_pkg::addr_t i_commit_start_pc,
    input  wire bpu_pkg::addr_t i_commit_fallthru,
    input  wire bpu_pkg::addr_t i_commit_target,
    input  wire                 i_commit_taken,
    input  wire                 i_ftq_rdy,
    output logic                o_pred_vld,
    output bpu_pkg::addr_t      o_pred_start,
    output bpu_pkg::addr_t      o_pred_end,
    output bpu_pkg::addr_t      o_pred_next,
    output logic                o_pred_taken,
    output bpu_pkg::addr_t      o_pred_target,
    output logic                o_pred_hit,
    output bpu_pkg::ghist_t     o_pred_ghist
);

    wire             advance;
    wire             s2_vld;
    bpu_pkg::addr_t  s0_pc;
    wire             s0_hit;
    wire             s0_taken;
    bpu_pkg::addr_t  s0_fallthru;
    bpu_pkg::addr_t  s0_target;
    bpu_pkg::addr_t  s0_next;
    bpu_pkg::ghist_t spec_hist;

    // only conditional commits train the table
    wire ubtb_update = i_commit_vld && i_commit_is_cond;

    bpu_ctrl u_bpu_ctrl (
        .clk          (clk),
        .rst          (rst),
        .i_squash_vld (i_squash_vld),
        .i_ftq_rdy    (i_ftq_rdy),
        .o_advance    (advance),
        .o_s1_vld     (),
        .o_s2_vld     (s2_vld)
    );

    fetch_pc_gen u_fetch_pc_gen (
        .clk          (clk),
        .rst          (rst),
        .i_advance    (advance),
        .i_squash_vld (i_squash_vld),
        .i_squash_pc  (i_squash_pc),
        .i_hit        (s0_hit),
        .i_next_pc    (s0_next),
        .o_pc         (s0_pc)
    );

    branch_history u_branch_history (
        .clk              (clk),
        .rst              (rst),
        .i_advance        (advance),
        .i_squash_vld     (i_squash_vld),
        .i_lookup_hit     (s0_hit),
        .i_lookup_taken   (s0_taken),
        .i_commit_vld     (i_commit_vld),
        .i_commit_is_cond (i_commit_is_cond),
        .i_commit_taken   (i_commit_taken),
        .o_spec_hist      (spec_hist)
    );

    ubtb u_ubtb (
        .clk               (clk),
        .rst               (rst),
        .i_lookup_pc       (s0_pc),
        .o_hit             (s0_hit),
        .o_taken           (s0_taken),
        .o_fallthru        (s0_fallthru),
        .o_target          (s0_target),
        .o_next_pc         (s0_next),
        .i_update          (ubtb_update),
        .i_update_pc       (i_commit_start_pc),
        .i_update_fallthru (i_commit_fallthru),
        .i_update_target   (i_commit_target),
        .i_update_taken    (i_commit_taken)
    );

    pred_pipe u_pred_pipe (
        .clk           (clk),
        .rst           (rst),
        .i_advance     (advance),
        .i_s2_vld      (s2_vld),
        .i_s0_pc       (s0_pc),
        .i_s0_hit      (s0_hit),
        .i_s0_taken    (s0_taken),
        .i_s0_fallthru (s0_fallthru),
        .i_s0_target   (s0_target),
        .i_s0_next     (s0_next),
        .i_s0_hist     (spec_hist),
        .i_ftq_rdy     (i_ftq_rdy),
        .o_pred_vld    (o_pred_vld),
        .o_pred_start  (o_pred_start),
        .o_pred_end    (o_pred_end),
        .o_pred_next   (o_pred_next),
        .o_pred_taken  (o_pred_taken),
        .o_pred_target (o_pred_target),
        .o_pred_hit    (o_pred_hit),
        .o_pred_ghist  (o_pred_ghist)
    );

endmodule

`default_nettype wire

// ==== design/branch_history.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "bpu_defs.svh"

module branch_history (
    input  wire              clk,
    input  wire              rst,
    input  wire              i_advance,
    input  wire              i_squash_vld,
    input  wire              i_lookup_hit,
    input  wire              i_lookup_taken,
    input  wire              i_commit_vld,
    input  wire              i_commit_is_cond,
    input  wire              i_commit_taken,
    output bpu_pkg::ghist_t  o_spec_hist
);

    localparam int unsigned HL = `BPU_HIST_LEN;

    bpu_pkg::ghist_t arch_q;
    bpu_pkg::ghist_t arch_next;
    logic            commit_cond;

    // only conditional branches enter the history
    assign commit_cond = i_commit_vld && i_commit_is_cond;

    always_comb begin
        arch_next = arch_q;
        if (commit_cond) begin
            arch_next = {arch_q[HL-2:0], i_commit_taken};
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            arch_q <= '0;
        end else begin
            arch_q <= arch_next;
        end
    end

    // speculative copy, rebuilt from committed state on squash
    always_ff @(posedge clk) begin
        if (rst) begin
            o_spec_hist <= '0;
        end else if (i_squash_vld) begin
            // includes a commit landing in the squash cycle
            o_spec_hist <= arch_next;
        end else if (i_advance && i_lookup_hit) begin
            o_spec_hist <= {o_spec_hist[HL-2:0], i_lookup_taken};
        end
    end

endmodule

`default_nettype wire

// ==== design/fetch_pc_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "bpu_defs.svh"

module fetch_pc_gen (
    input  wire                 clk,
    input  wire                 rst,
    input  wire                 i_advance,
    input  wire                 i_squash_vld,
    input  wire bpu_pkg::addr_t i_squash_pc,
    input  wire                 i_hit,
    input  wire bpu_pkg::addr_t i_next_pc,
    output bpu_pkg::addr_t      o_pc
);

    localparam int unsigned OFF_W = `BPU_OFF_W;

    bpu_pkg::addr_t seq_pc;
    logic           pc_aligned;
    logic           squash_aligned;
    logic           next_aligned;

    // sequential fall-through block
    assign seq_pc = o_pc + bpu_pkg::addr_t'(`BPU_FETCH_BYTES);

    // squash wins over any prediction in the same cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            o_pc <= `BPU_INIT_PC;
        end else if (i_squash_vld) begin
            o_pc <= i_squash_pc;
        end else if (i_advance) begin
            if (i_hit) begin
                o_pc <= i_next_pc;
            end else begin
                o_pc <= seq_pc;
            end
        end
    end

    assign pc_aligned     = (o_pc[OFF_W-1:0] == '0);
    assign squash_aligned = (i_squash_pc[OFF_W-1:0] == '0);
    assign next_aligned   = (i_next_pc[OFF_W-1:0] == '0);

    // aligned sources keep the fetch address on a block boundary
    a_pc_aligned: assert property (@(posedge clk) disable iff (rst)
        (pc_aligned && (!i_squash_vld || squash_aligned) && (!i_hit || next_aligned))
        |=> pc_aligned);

endmodule

`default_nettype wire

// ==== design/pred_pipe.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "bpu_defs.svh"

module pred_pipe (
    input  wire                  clk,
    input  wire                  rst,
    input  wire                  i_advance,
    input  wire                  i_s2_vld,
    input  wire bpu_pkg::addr_t  i_s0_pc,
    input  wire                  i_s0_hit,
    input  wire                  i_s0_taken,
    input  wire bpu_pkg::addr_t  i_s0_fallthru,
    input  wire bpu_pkg::addr_t  i_s0_target,
    input  wire bpu_pkg::addr_t  i_s0_next,
    input  wire bpu_pkg::ghist_t i_s0_hist,
    input  wire                  i_ftq_rdy,
    output logic                 o_pred_vld,
    output bpu_pkg::addr_t       o_pred_start,
    output bpu_pkg::addr_t       o_pred_end,
    output bpu_pkg::addr_t       o_pred_next,
    output logic                 o_pred_taken,
    output bpu_pkg::addr_t       o_pred_target,
    output logic                 o_pred_hit,
    output bpu_pkg::ghist_t      o_pred_ghist
);

    // s1 copy of the lookup
    bpu_pkg::addr_t  s1_pc;
    logic            s1_hit;
    logic            s1_taken;
    bpu_pkg::addr_t  s1_fallthru;
    bpu_pkg::addr_t  s1_target;
    bpu_pkg::addr_t  s1_next;
    bpu_pkg::ghist_t s1_hist;

    // s2 copy
    bpu_pkg::addr_t  s2_pc;
    logic            s2_hit;
    logic            s2_taken;
    bpu_pkg::addr_t  s2_fallthru;
    bpu_pkg::addr_t  s2_target;
    bpu_pkg::addr_t  s2_next;
    bpu_pkg::ghist_t s2_hist;

    // payload only, validity lives in the controller
    always_ff @(posedge clk) begin
        if (i_advance) begin
            s1_pc       <= i_s0_pc;
            s1_hit      <= i_s0_hit;
            s1_taken    <= i_s0_taken;
            s1_fallthru <= i_s0_fallthru;
            s1_target   <= i_s0_target;
            s1_next     <= i_s0_next;
            s1_hist     <= i_s0_hist;

            s2_pc       <= s1_pc;
            s2_hit      <= s1_hit;
            s2_taken    <= s1_taken;
            s2_fallthru <= s1_fallthru;
            s2_target   <= s1_target;
            s2_next     <= s1_next;
            s2_hist     <= s1_hist;
        end
    end

    // fetch range is [start, end)
    assign o_pred_vld    = i_s2_vld;
    assign o_pred_start  = s2_pc;
    assign o_pred_end    = s2_hit ? s2_fallthru : s2_pc + bpu_pkg::addr_t'(`BPU_FETCH_BYTES);
    // a miss falls straight through to the next block
    assign o_pred_next   = s2_hit ? s2_next : o_pred_end;
    assign o_pred_taken  = s2_hit && s2_taken;
    assign o_pred_target = s2_hit ? s2_target : '0;
    assign o_pred_hit    = s2_hit;
    assign o_pred_ghist  = s2_hist;

    // queue stall freezes the offered block
    a_stall_stable: assert property (@(posedge clk) disable iff (rst)
        (o_pred_vld && !i_ftq_rdy) |=>
            ($stable(o_pred_start) && $stable(o_pred_end) && $stable(o_pred_next) &&
             $stable(o_pred_taken) && $stable(o_pred_target) && $stable(o_pred_hit) &&
             $stable(o_pred_ghist)));

endmodule

`default_nettype wire

// ==== design/ubtb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "bpu_defs.svh"

module ubtb #(
    parameter int unsigned DEPTH = `BPU_UBTB_DEPTH
) (
    input  wire                 clk,
    input  wire                 rst,
    input  wire bpu_pkg::addr_t i_lookup_pc,
    output logic                o_hit,
    output logic                o_taken,
    output bpu_pkg::addr_t      o_fallthru,
    output bpu_pkg::addr_t      o_target,
    output bpu_pkg::addr_t      o_next_pc,
    input  wire                 i_update,
    input  wire bpu_pkg::addr_t i_update_pc,
    input  wire bpu_pkg::addr_t i_update_fallthru,
    input  wire bpu_pkg::addr_t i_update_target,
    input  wire                 i_update_taken
);

    localparam int unsigned OFF_W = `BPU_OFF_W;
    localparam int unsigned IDX_W = $clog2(DEPTH);
    localparam int unsigned TAG_W = `BPU_XLEN - OFF_W - IDX_W;

    // entry fields
    logic [DEPTH-1:0] valid_q;
    logic [TAG_W-1:0] tag_q      [DEPTH];
    bpu_pkg::addr_t   fallthru_q [DEPTH];
    bpu_pkg::addr_t   target_q   [DEPTH];
    logic             taken_q    [DEPTH];

    logic [IDX_W-1:0] lk_idx;
    logic [TAG_W-1:0] lk_tag;
    logic [IDX_W-1:0] up_idx;
    logic [TAG_W-1:0] up_tag;

    // index sits right above the block offset, tag is the rest
    assign lk_idx = i_lookup_pc[OFF_W +: IDX_W];
    assign lk_tag = i_lookup_pc[`BPU_XLEN-1 -: TAG_W];
    assign up_idx = i_update_pc[OFF_W +: IDX_W];
    assign up_tag = i_update_pc[`BPU_XLEN-1 -: TAG_W];

    // combinational lookup
    assign o_hit      = valid_q[lk_idx] && (tag_q[lk_idx] == lk_tag);
    assign o_taken    = taken_q[lk_idx];
    assign o_fallthru = fallthru_q[lk_idx];
    assign o_target   = target_q[lk_idx];
    assign o_next_pc  = taken_q[lk_idx] ? target_q[lk_idx] : fallthru_q[lk_idx];

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= '0;
        end else if (i_update) begin
            valid_q[up_idx] <= 1'b1;
        end
    end

    // whole entry rewritten, last outcome wins
    always_ff @(posedge clk) begin
        if (i_update) begin
            tag_q[up_idx]      <= up_tag;
            fallthru_q[up_idx] <= i_update_fallthru;
            target_q[up_idx]   <= i_update_target;
            taken_q[up_idx]    <= i_update_taken;
        end
    end

    // committed blocks always end past their start
    a_hit_fallthru: assert property (@(posedge clk) disable iff (rst)
        o_hit |-> (o_fallthru > i_lookup_pc));

endmodule

`default_nettype wire

// ==== include/bpu_defs.svh ====
`ifndef BPU_DEFS_SVH
`define BPU_DEFS_SVH

// byte address width
`define BPU_XLEN 32

// bytes covered by one fetch block
`define BPU_FETCH_BYTES 16

// ubtb entries, power of two
`define BPU_UBTB_DEPTH 32

// global history bits
`define BPU_HIST_LEN 8

// first fetch address after reset
`define BPU_INIT_PC 32'h8000_0000

// block offset bits below the ubtb index
`define BPU_OFF_W ($clog2(`BPU_FETCH_BYTES))

// index bits for the default table depth
`define BPU_UBTB_IDX_W ($clog2(`BPU_UBTB_DEPTH))

`endif

// ==== sim/tb_bpu.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "bpu_defs.svh"

module tb_bpu;

    localparam int CLK_PERIOD    = 20;
    localparam int RESET_CYCLES  = 10;
    localparam int FIRST_XFERS   = 40;
    localparam int ROUNDS        = 8;
    localparam int ROUND_XFERS   = 24;
    localparam int ROUND_COMMITS = 4;
    localparam int REGION_BLOCKS = 64;
    // ready is low a quarter of the time, so 16 cycles per block is ample
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + 16 * (FIRST_XFERS + ROUNDS * ROUND_XFERS)
                                     + 64 * ROUNDS + 100;

    logic            clk;
    logic            rst;
    logic            i_squash_vld;
    bpu_pkg::addr_t  i_squash_pc;
    logic            i_commit_vld;
    logic            i_commit_is_cond;
    bpu_pkg::addr_t  i_commit_start_pc;
    bpu_pkg::addr_t  i_commit_fallthru;
    bpu_pkg::addr_t  i_commit_target;
    logic            i_commit_taken;
    logic            i_ftq_rdy;
    logic            o_pred_vld;
    bpu_pkg::addr_t  o_pred_start;
    bpu_pkg::addr_t  o_pred_end;
    bpu_pkg::addr_t  o_pred_next;
    logic            o_pred_taken;
    bpu_pkg::addr_t  o_pred_target;
    logic            o_pred_hit;
    bpu_pkg::ghist_t o_pred_ghist;

    // reference model, table mirror and committed history
    logic               m_valid [`BPU_UBTB_DEPTH];
    bpu_pkg::ubtb_tag_t m_tag   [`BPU_UBTB_DEPTH];
    bpu_pkg::addr_t     m_fall  [`BPU_UBTB_DEPTH];
    bpu_pkg::addr_t     m_tgt   [`BPU_UBTB_DEPTH];
    logic               m_taken [`BPU_UBTB_DEPTH];
    bpu_pkg::ghist_t    m_arch;

    // expected start and history of the next transferred block
    bpu_pkg::addr_t  exp_start;
    bpu_pkg::ghist_t exp_hist;
    int unsigned     xfer_count;
    int unsigned     hits_seen;
    int unsigned     stalls_seen;
    logic [31:0]     lcg_state;
    string           test_name;

    bpu_top u_bpu_top (
        .clk               (clk),
        .rst               (rst),
        .i_squash_vld      (i_squash_vld),
        .i_squash_pc       (i_squash_pc),
        .i_commit_vld      (i_commit_vld),
        .i_commit_is_cond  (i_commit_is_cond),
        .i_commit_start_pc (i_commit_start_pc),
        .i_commit_fallthru (i_commit_fallthru),
        .i_commit_target   (i_commit_target),
        .i_commit_taken    (i_commit_taken),
        .i_ftq_rdy         (i_ftq_rdy),
        .o_pred_vld        (o_pred_vld),
        .o_pred_start      (o_pred_start),
        .o_pred_end        (o_pred_end),
        .o_pred_next       (o_pred_next),
        .o_pred_taken      (o_pred_taken),
        .o_pred_target     (o_pred_target),
        .o_pred_hit        (o_pred_hit),
        .o_pred_ghist      (o_pred_ghist)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("SOME TESTS FAILED");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check_value(input string what, input logic [31:0] exp, input logic [31:0] act);
        assert (exp === act) else
            report_failure($sformatf("FAIL %s %s: expected %h, actual %h",
                                     test_name, what, exp, act));
    endtask

    // upper half of the LCG state, the low bits repeat too quickly
    function automatic logic [31:0] draw_random();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return {16'b0, lcg_state[31:16]};
    endfunction

    function automatic bpu_pkg::ubtb_idx_t table_index(input bpu_pkg::addr_t a);
        return bpu_pkg::ubtb_idx_t'(a / `BPU_FETCH_BYTES);
    endfunction

    function automatic bpu_pkg::ubtb_tag_t table_tag(input bpu_pkg::addr_t a);
        return bpu_pkg::ubtb_tag_t'(a / (`BPU_FETCH_BYTES * `BPU_UBTB_DEPTH));
    endfunction

    task automatic score_transfer();
        bpu_pkg::ubtb_idx_t idx;
        logic               hit;
        logic               e_taken;
        bpu_pkg::addr_t     e_end;
        bpu_pkg::addr_t     e_tgt;
        bpu_pkg::addr_t     e_next;
        idx     = table_index(exp_start);
        hit     = m_valid[idx] && (m_tag[idx] == table_tag(exp_start));
        e_end   = hit ? m_fall[idx] : exp_start + `BPU_FETCH_BYTES;
        e_taken = hit && m_taken[idx];
        e_tgt   = hit ? m_tgt[idx] : '0;
        e_next  = e_taken ? e_tgt : e_end;
        check_value("start", exp_start, o_pred_start);
        check_value("end", e_end, o_pred_end);
        check_value("next", e_next, o_pred_next);
        check_value("taken", 32'(e_taken), 32'(o_pred_taken));
        check_value("target", e_tgt, o_pred_target);
        check_value("hit", 32'(hit), 32'(o_pred_hit));
        check_value("ghist", 32'(exp_hist), 32'(o_pred_ghist));
        // next block chains on, history moves only on a hit
        exp_start = e_next;
        if (hit) begin
            exp_hist = {exp_hist[`BPU_HIST_LEN-2:0], e_taken};
            hits_seen++;
        end
        xfer_count++;
    endtask

    task automatic run_cycle(input logic rdy);
        @(negedge clk);
        i_ftq_rdy        = rdy;
        i_squash_vld     = 1'b0;
        i_commit_vld     = 1'b0;
        i_commit_is_cond = 1'b0;
        // block offered with ready high leaves at the coming rising edge
        if (o_pred_vld && rdy) begin
            score_transfer();
        end else if (o_pred_vld) begin
            stalls_seen++;
        end
    endtask

    task automatic run_transfers(input int unsigned n);
        int unsigned goal;
        goal = xfer_count + n;
        while (xfer_count < goal) begin
            run_cycle((draw_random() % 4) != 0);
        end
    endtask

    task automatic commit_cycle(input logic is_cond, input bpu_pkg::addr_t start,
                                input bpu_pkg::addr_t fall, input bpu_pkg::addr_t tgt,
                                input logic taken, input logic squash);
        bpu_pkg::ubtb_idx_t idx;
        @(negedge clk);
        i_ftq_rdy         = 1'b0;
        i_commit_vld      = 1'b1;
        i_commit_is_cond  = is_cond;
        i_commit_start_pc = start;
        i_commit_fallthru = fall;
        i_commit_target   = tgt;
        i_commit_taken    = taken;
        i_squash_vld      = squash;
        i_squash_pc       = start;
        // model takes the commit at the same edge as the DUT
        if (is_cond) begin
            idx          = table_index(start);
            m_valid[idx] = 1'b1;
            m_tag[idx]   = table_tag(start);
            m_fall[idx]  = fall;
            m_tgt[idx]   = tgt;
            m_taken[idx] = taken;
            m_arch       = {m_arch[`BPU_HIST_LEN-2:0], taken};
        end
        if (squash) begin
            exp_start = start;
            exp_hist  = m_arch;
        end
    endtask

    // freeze the full pipe, commit a few blocks, squash onto the last one
    task automatic commit_round(input int round);
        bpu_pkg::addr_t start;
        bpu_pkg::addr_t fall;
        bpu_pkg::addr_t tgt;
        run_cycle(1'b0);
        while (!o_pred_vld) begin
            run_cycle(1'b0);
        end
        for (int i = 0; i < ROUND_COMMITS; i++) begin
            start = `BPU_INIT_PC + (draw_random() % REGION_BLOCKS) * `BPU_FETCH_BYTES;
            fall  = start + (1 + draw_random() % 2) * `BPU_FETCH_BYTES;
            tgt   = `BPU_INIT_PC + (draw_random() % REGION_BLOCKS) * `BPU_FETCH_BYTES;
            // slot 1 is an unconditional block the table must ignore
            commit_cycle(i != 1, start, fall, tgt, ((i + round) % 2) == 1,
                         i == ROUND_COMMITS - 1);
        end
    endtask

    // idle state plus two advances keep the output quiet after reset
    a_quiet_after_reset: assert property (@(posedge clk)
        (!rst && ($past(rst, 1) || $past(rst, 2) || $past(rst, 3))) |-> !o_pred_vld)
        else report_failure("a block was offered too early after reset");

    a_hold_on_stall: assert property (@(posedge clk) disable iff (rst)
        (o_pred_vld && !i_ftq_rdy && !i_squash_vld) |=>
            (o_pred_vld && $stable(o_pred_start) && $stable(o_pred_end) &&
             $stable(o_pred_next) && $stable(o_pred_taken) && $stable(o_pred_target) &&
             $stable(o_pred_hit) && $stable(o_pred_ghist)))
        else report_failure("offered block changed or vanished while the queue was stalled");

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        report_failure("watchdog timeout, transfers stopped arriving");
    end

    initial begin
        clk               = 1'b0;
        rst               = 1'b1;
        i_squash_vld      = 1'b0;
        i_squash_pc       = '0;
        i_commit_vld      = 1'b0;
        i_commit_is_cond  = 1'b0;
        i_commit_start_pc = '0;
        i_commit_fallthru = '0;
        i_commit_target   = '0;
        i_commit_taken    = 1'b0;
        i_ftq_rdy         = 1'b0;
        lcg_state         = 32'h6c0f;
        m_arch            = '0;
        exp_start         = `BPU_INIT_PC;
        exp_hist          = '0;
        xfer_count        = 0;
        hits_seen         = 0;
        stalls_seen       = 0;
        for (int i = 0; i < `BPU_UBTB_DEPTH; i++) begin
            m_valid[i] = 1'b0;
        end
        test_name = "reset";
        repeat (RESET_CYCLES) @(negedge clk);
        rst = 1'b0;

        test_name = "sequential_miss";
        run_transfers(FIRST_XFERS);

        for (int r = 0; r < ROUNDS; r++) begin
            test_name = $sformatf("commit_round_%0d", r);
            commit_round(r);
            run_transfers(ROUND_XFERS);
        end

        if (hits_seen == 0 || stalls_seen == 0) begin
            report_failure("stimulus never produced a predicted hit or a queue stall");
        end else begin
            $display("ALL TESTS PASSED");
            $finish;
        end
    end

endmodule

`default_nettype wire
